// ==== common/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// core wide constants
////////////////////////////////////////////////////////////////////////////

// first fetch address after reset, the usual boot vector.
`define MIPS_RESET_PC 32'hBFC0_0000

// data path width in bits.
`define MIPS_WORD_W 32

// number of general purpose registers.
`define MIPS_NREGS 32

`endif

// ==== common/mips_pkg.sv ====
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]        word_t;      // one data word.
    typedef logic [$clog2(`MIPS_NREGS)-1:0] creg_addr_t; // register number.
    typedef logic [5:0]                     opcode_t;    // instr[31:26].
    typedef logic [5:0]                     funct_t;     // instr[5:0] of R-type.

    ////////////////////////////////////////////////////////////////////////
    // opcode and function field values
    ////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_SPECIAL = 6'h00; // R-type, see funct.
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    // operations the execute stage knows about.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE
    } alu_op_t;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import mips_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////////////////

    // fetch to decode, one word off the instruction bus.
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_data_t;

    // decode to execute, operands already resolved.
    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_t    alu_op;
        word_t      op_a;      // rs value.
        word_t      op_b;      // rt value or the extended immediate.
        word_t      br_offset; // sign extended, in words.
        creg_addr_t dst;
        logic       wen;
    } decode_data_t;

    // execute result, also what the retire register holds.
    typedef struct packed {
        logic       valid;
        word_t      pc;
        creg_addr_t dst;
        logic       wen;
        word_t      result;
    } exec_data_t;

    // result of the instruction in execute, fed back to decode.
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      data;
    } bypass_upd_t;

endpackage

`default_nettype wire

// ==== design/fetch/fetch.sv ====
`default_nettype none

`include "mips_macros.svh"

module fetch import mips_pkg::*; import pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  word_t       redirect_pc,
    output logic        inst_req,
    output word_t       inst_addr,
    input  logic        inst_ack,
    input  word_t       inst_rdata,
    output fetch_data_t fetch_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_ACK_LOW
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;      // address of the next request.
    word_t        pc_next;
    logic         discard; // word in flight belongs to a squashed path.
    logic         accept;
    logic         start;

    assign accept   = (state == S_REQ) && inst_ack;  // phase 2 seen, word is on the bus.
    assign start    = (state != S_REQ) && !inst_ack; // bus idle, open a new handshake.
    assign inst_req = (state == S_REQ);

    assign fetch_data.valid = accept && !discard;
    assign fetch_data.pc    = inst_addr;
    assign fetch_data.instr = inst_rdata;

    always_comb begin
        pc_next = pc;
        if (redirect) begin
            pc_next = redirect_pc;                   // a taken branch wins over sequential flow.
        end else if (fetch_data.valid) begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            pc      <= `MIPS_RESET_PC;
            discard <= 1'b0;
        end else begin
            pc <= pc_next;
            case (state)
                S_IDLE:    if (!inst_ack) state <= S_REQ;
                S_REQ:     if (inst_ack) state <= S_ACK_LOW;
                S_ACK_LOW: if (!inst_ack) state <= S_REQ;
                default:   state <= S_IDLE;
            endcase
            // a redirect mid handshake cannot move inst_addr, so the word is dropped instead.
            if (accept) begin
                discard <= 1'b0;
            end else if (redirect && inst_req) begin
                discard <= 1'b1;
            end
        end
    end

    // address is latched once per request and then held until the handshake closes.
    always_ff @(posedge clk) begin
        if (start) begin
            inst_addr <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_reg.sv ====
`default_nettype none

module pipe_reg import pipe_pkg::*; #(
    parameter type payload_t = fetch_data_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    ////////////////////////////////////////////////////////////////////////
    // one stage of the pipe
    ////////////////////////////////////////////////////////////////////////

    // the payload moves on every clock edge.
    always_ff @(posedge clk) begin
        q <= d;
        if (reset || flush) begin
            q.valid <= 1'b0; // turns the slot into a bubble.
        end
    end

endmodule

`default_nettype wire

// ==== design/decode.sv ====
`default_nettype none

module decode import mips_pkg::*; import pipe_pkg::*; (
    input  fetch_data_t  in,
    output creg_addr_t   rs_addr,
    output creg_addr_t   rt_addr,
    input  word_t        rs_data,
    input  word_t        rt_data,
    input  bypass_upd_t  exec_bypass,
    output decode_data_t out
);

    opcode_t    opcode;
    funct_t     funct;
    creg_addr_t rd_addr;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      rs_val;
    word_t      rt_val;

    assign opcode   = in.instr[31:26];
    assign rs_addr  = in.instr[25:21];
    assign rt_addr  = in.instr[20:16];
    assign rd_addr  = in.instr[15:11];
    assign funct    = in.instr[5:0];
    assign imm_sext = {{16{in.instr[15]}}, in.instr[15:0]};
    assign imm_zext = {16'h0000, in.instr[15:0]};

    // older result sitting in execute overrides the register file copy.
    assign rs_val = (exec_bypass.wen && exec_bypass.addr == rs_addr) ? exec_bypass.data : rs_data;
    assign rt_val = (exec_bypass.wen && exec_bypass.addr == rt_addr) ? exec_bypass.data : rt_data;

    always_comb begin
        out.valid     = in.valid;
        out.pc        = in.pc;
        out.alu_op    = ALU_ADD;
        out.op_a      = rs_val;
        out.op_b      = rt_val;
        out.br_offset = imm_sext;
        out.dst       = rd_addr;
        out.wen       = 1'b0;              // unknown words retire as no-ops.
        case (opcode)
            OP_SPECIAL: begin
                out.wen = 1'b1;
                case (funct)
                    FN_ADDU: out.alu_op = ALU_ADD;
                    FN_SUBU: out.alu_op = ALU_SUB;
                    FN_AND:  out.alu_op = ALU_AND;
                    FN_OR:   out.alu_op = ALU_OR;
                    FN_XOR:  out.alu_op = ALU_XOR;
                    FN_SLT:  out.alu_op = ALU_SLT;
                    default: out.wen = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                out.alu_op = ALU_ADD;
                out.op_b   = imm_sext;
                out.dst    = rt_addr;
                out.wen    = 1'b1;
            end
            OP_ORI: begin
                out.alu_op = ALU_OR;
                out.op_b   = imm_zext;
                out.dst    = rt_addr;
                out.wen    = 1'b1;
            end
            OP_LUI: begin
                out.alu_op = ALU_LUI;
                out.op_b   = imm_zext;       // shifted up in execute.
                out.dst    = rt_addr;
                out.wen    = 1'b1;
            end
            OP_BEQ:  out.alu_op = ALU_BEQ;
            OP_BNE:  out.alu_op = ALU_BNE;
            default: out.alu_op = ALU_ADD;
        endcase
        if (out.dst == '0) begin
            out.wen = 1'b0;                  // r0 is never written.
        end
    end

endmodule

`default_nettype wire

// ==== design/execute.sv ====
`default_nettype none

module execute import mips_pkg::*; import pipe_pkg::*; (
    input  decode_data_t in,
    output exec_data_t   out,
    output bypass_upd_t  exec_bypass,
    output logic         redirect,
    output word_t        redirect_pc
);

    word_t result;
    logic  taken;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (in.alu_op)
            ALU_ADD: result = in.op_a + in.op_b;
            ALU_SUB: result = in.op_a - in.op_b;
            ALU_AND: result = in.op_a & in.op_b;
            ALU_OR:  result = in.op_a | in.op_b;
            ALU_XOR: result = in.op_a ^ in.op_b;
            ALU_SLT: result = word_t'($signed(in.op_a) < $signed(in.op_b));
            ALU_LUI: result = {in.op_b[15:0], 16'h0000};
            ALU_BEQ: taken  = (in.op_a == in.op_b);
            ALU_BNE: taken  = (in.op_a != in.op_b);
            default: result = '0;
        endcase
    end

    // branches resolve here, there is no delay slot.
    assign redirect    = in.valid && taken;
    assign redirect_pc = in.pc + 32'd4 + {in.br_offset[29:0], 2'b00};

    assign out.valid  = in.valid;
    assign out.pc     = in.pc;
    assign out.dst    = in.dst;
    assign out.wen    = in.wen;
    assign out.result = result;

    assign exec_bypass.wen  = in.valid && in.wen; // bubbles never forward.
    assign exec_bypass.addr = in.dst;
    assign exec_bypass.data = result;

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`default_nettype none

`include "mips_macros.svh"

module regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wen,
    input  creg_addr_t waddr,
    input  word_t      wdata,
    input  creg_addr_t raddr0,
    input  creg_addr_t raddr1,
    output word_t      rdata0,
    output word_t      rdata1
);

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-first reads, so a retiring value reaches decode in the same cycle.
    assign rdata0 = (raddr0 == '0) ? '0 : (wen && waddr == raddr0) ? wdata : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : (wen && waddr == raddr1) ? wdata : regs[raddr1];

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`default_nettype none

module datapath import mips_pkg::*; import pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_req,
    output word_t      inst_addr,
    input  logic       inst_ack,
    input  word_t      inst_rdata,
    output logic       rfw_wen,
    output creg_addr_t rfw_addr,
    output word_t      rfw_data,
    output word_t      rt_pc
);

    fetch_data_t  fetch_data;
    fetch_data_t  decode_in;
    decode_data_t decode_out;
    decode_data_t exec_in;
    exec_data_t   exec_out;
    exec_data_t   retire_in;
    bypass_upd_t  exec_bypass;

    logic         redirect;
    word_t        redirect_pc;
    creg_addr_t   rs_addr;
    creg_addr_t   rt_addr;
    word_t        rs_data;
    word_t        rt_data;

    ////////////////////////////////////////////////////////////////////////
    // front end
    ////////////////////////////////////////////////////////////////////////

    fetch fetch (.clk, .reset, .redirect, .redirect_pc,
                 .inst_req, .inst_addr, .inst_ack, .inst_rdata,
                 .fetch_data);

    pipe_reg #(.payload_t(fetch_data_t)) d_reg (.clk, .reset, .flush(redirect),
                                                .d(fetch_data), .q(decode_in));

    decode decode (.in(decode_in), .rs_addr, .rt_addr, .rs_data, .rt_data,
                   .exec_bypass, .out(decode_out));

    ////////////////////////////////////////////////////////////////////////
    // back end
    ////////////////////////////////////////////////////////////////////////

    pipe_reg #(.payload_t(decode_data_t)) e_reg (.clk, .reset, .flush(redirect),
                                                 .d(decode_out), .q(exec_in));

    execute execute (.in(exec_in), .out(exec_out), .exec_bypass,
                     .redirect, .redirect_pc);

    // the branch itself moves on to retire, only younger slots are squashed.
    pipe_reg #(.payload_t(exec_data_t)) r_reg (.clk, .reset, .flush(1'b0),
                                               .d(exec_out), .q(retire_in));

    regfile regfile (.clk, .reset,
                     .wen(rfw_wen), .waddr(rfw_addr), .wdata(rfw_data),
                     .raddr0(rs_addr), .raddr1(rt_addr),
                     .rdata0(rs_data), .rdata1(rt_data));

    // retire ports mirror the register file write.
    assign rfw_wen  = retire_in.valid && retire_in.wen;
    assign rfw_addr = retire_in.dst;
    assign rfw_data = retire_in.result;
    assign rt_pc    = retire_in.pc;

endmodule

`default_nettype wire

// ==== tb/datapath_props.sv ====
`default_nettype none

module datapath_props import mips_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       inst_req,
    input logic       inst_ack,
    input word_t      inst_addr,
    input logic       rfw_wen,
    input creg_addr_t rfw_addr
);

    ////////////////////////////////////////////////////////////////////////
    // instruction bus
    ////////////////////////////////////////////////////////////////////////

    // a new request waits until the previous ack is gone.
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        !inst_req && inst_ack |=> !inst_req)
        else $error("inst_req rose while inst_ack was still high");

    addr_held: assert property (@(posedge clk) disable iff (reset)
        inst_req |=> $stable(inst_addr))
        else $error("inst_addr moved during an open request");

    ////////////////////////////////////////////////////////////////////////
    // retire port
    ////////////////////////////////////////////////////////////////////////

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !rfw_wen)
        else $error("rfw_wen was high right after reset");

    no_r0_retire: assert property (@(posedge clk) disable iff (reset)
        rfw_wen |-> rfw_addr != '0)
        else $error("a write to r0 showed up on the retire port");

endmodule

bind datapath datapath_props bus_checks (
    .clk       (clk),
    .reset     (reset),
    .inst_req  (inst_req),
    .inst_ack  (inst_ack),
    .inst_addr (inst_addr),
    .rfw_wen   (rfw_wen),
    .rfw_addr  (rfw_addr)
);

`default_nettype wire

// ==== tb/datapath_tb.sv ====
`default_nettype none

`include "mips_macros.svh"

module datapath_tb import mips_pkg::*; ();

    localparam int unsigned RAND_SEED    = 32'h7b52_5bdb;
    localparam int          REQ_TIMEOUT  = 50;  // cycles the memory waits for a level on inst_req.
    localparam int          RETIRE_LIMIT = 200; // cycles allowed until the next retire.
    localparam int          QUIET_CYCLES = 40;  // the self loop at the end must stay silent.

    logic       clk = 1'b0;
    logic       reset;
    logic       inst_req;
    word_t      inst_addr;
    logic       inst_ack;
    word_t      inst_rdata;
    logic       rfw_wen;
    creg_addr_t rfw_addr;
    word_t      rfw_data;
    word_t      rt_pc;

    word_t      program_words [$]; // instruction memory, word 0 sits at the reset pc.
    word_t      exp_pc [$];
    creg_addr_t exp_reg [$];
    word_t      exp_val [$];

    datapath UUT (
        .clk        (clk),
        .reset      (reset),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .rfw_wen    (rfw_wen),
        .rfw_addr   (rfw_addr),
        .rfw_data   (rfw_data),
        .rt_pc      (rt_pc)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // encoders and helpers
    ////////////////////////////////////////////////////////////////////////

    function automatic word_t r_type_word(funct_t fn, creg_addr_t rd, creg_addr_t rs,
                                          creg_addr_t rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type_word(opcode_t op, creg_addr_t rt, creg_addr_t rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // past the program end every address holds beq r0, r0, -1.
    function automatic word_t word_at(word_t addr);
        int unsigned index;
        index = (addr - `MIPS_RESET_PC) >> 2;
        if (index < program_words.size()) begin
            return program_words[index];
        end
        return i_type_word(OP_BEQ, 5'd0, 5'd0, 16'hFFFF);
    endfunction

    task automatic add_step(input word_t instr, input logic writes, input creg_addr_t dst,
                            input word_t value);
        word_t pc;
        pc = `MIPS_RESET_PC + 32'(4 * program_words.size());
        program_words.push_back(instr);
        if (writes) begin
            exp_pc.push_back(pc);
            exp_reg.push_back(dst);
            exp_val.push_back(value);
        end
    endtask

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic wait_for_req(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (inst_req !== level) begin
            if (waited == REQ_TIMEOUT) begin
                $display("timeout: inst_req did not go to %0d within %0d cycles",
                         level, REQ_TIMEOUT);
                end_with_failure();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wait_for_retire(input int row);
        int waited;
        waited = 0;
        while (rfw_wen !== 1'b1) begin
            if (waited == RETIRE_LIMIT) begin
                $display("timeout: retire %0d of r%0d at pc 0x%08h never came",
                         row, exp_reg[row], exp_pc[row]);
                end_with_failure();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // program and expected register writes
    ////////////////////////////////////////////////////////////////////////

    task automatic load_program();
        // immediates and logic ops.
        add_step(i_type_word(OP_LUI, 5'd1, 5'd0, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);
        add_step(i_type_word(OP_ORI, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
        add_step(i_type_word(OP_ADDIU, 5'd2, 5'd0, 16'hFFFF), 1'b1, 5'd2, 32'hFFFF_FFFF);
        add_step(i_type_word(OP_ORI, 5'd3, 5'd0, 16'hF0F0), 1'b1, 5'd3, 32'h0000_F0F0);
        add_step(r_type_word(FN_AND, 5'd4, 5'd1, 5'd3), 1'b1, 5'd4, 32'h0000_5070);
        add_step(r_type_word(FN_OR, 5'd5, 5'd1, 5'd3), 1'b1, 5'd5, 32'h1234_F6F8);
        add_step(r_type_word(FN_XOR, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 32'hEDCB_A987);
        // dependent chain of three.
        add_step(i_type_word(OP_ADDIU, 5'd7, 5'd0, 16'h0005), 1'b1, 5'd7, 32'h0000_0005);
        add_step(r_type_word(FN_ADDU, 5'd8, 5'd7, 5'd7), 1'b1, 5'd8, 32'h0000_000A);
        add_step(r_type_word(FN_ADDU, 5'd9, 5'd8, 5'd7), 1'b1, 5'd9, 32'h0000_000F);
        // signed compares against a negative difference.
        add_step(r_type_word(FN_SUBU, 5'd10, 5'd7, 5'd9), 1'b1, 5'd10, 32'hFFFF_FFF6);
        add_step(r_type_word(FN_SLT, 5'd11, 5'd10, 5'd7), 1'b1, 5'd11, 32'h0000_0001);
        add_step(r_type_word(FN_SLT, 5'd12, 5'd7, 5'd10), 1'b1, 5'd12, 32'h0000_0000);
        add_step(r_type_word(FN_SLT, 5'd13, 5'd10, 5'd2), 1'b1, 5'd13, 32'h0000_0001);
        // sll is not supported and the r0 write is dropped.
        add_step(r_type_word(6'h00, 5'd21, 5'd0, 5'd7), 1'b0, 5'd0, 32'h0);
        add_step(i_type_word(OP_ADDIU, 5'd0, 5'd7, 16'h0007), 1'b0, 5'd0, 32'h0);
        add_step(r_type_word(FN_ADDU, 5'd14, 5'd0, 5'd7), 1'b1, 5'd14, 32'h0000_0005);
        // bne falls through, beq skips two words.
        add_step(i_type_word(OP_BNE, 5'd14, 5'd7, 16'h0005), 1'b0, 5'd0, 32'h0);
        add_step(i_type_word(OP_ADDIU, 5'd15, 5'd0, 16'h0100), 1'b1, 5'd15, 32'h0000_0100);
        add_step(i_type_word(OP_BEQ, 5'd7, 5'd14, 16'h0002), 1'b0, 5'd0, 32'h0);
        add_step(i_type_word(OP_ADDIU, 5'd16, 5'd0, 16'h0BAD), 1'b0, 5'd0, 32'h0);
        add_step(i_type_word(OP_ORI, 5'd17, 5'd0, 16'hDEAD), 1'b0, 5'd0, 32'h0);
        add_step(i_type_word(OP_ADDIU, 5'd18, 5'd15, 16'hFFF0), 1'b1, 5'd18, 32'h0000_00F0);
        add_step(r_type_word(FN_XOR, 5'd19, 5'd18, 5'd1), 1'b1, 5'd19, 32'h1234_5688);
        add_step(r_type_word(FN_ADDU, 5'd20, 5'd19, 5'd18), 1'b1, 5'd20, 32'h1234_5778);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // instruction memory and main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin : instruction_memory
        int unsigned delay;
        inst_ack   = 1'b0;
        inst_rdata = '0;
        delay      = $urandom(RAND_SEED); // seeds this process, the value is unused.
        forever begin
            wait_for_req(1'b1);
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            inst_rdata = word_at(inst_addr);
            inst_ack   = 1'b1;
            wait_for_req(1'b0);
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            inst_ack = 1'b0;
        end
    end

    initial begin : main_sequence
        reset = 1'b1;
        load_program();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int row = 0; row < exp_pc.size(); row++) begin
            wait_for_retire(row);
            check_equal("rt_pc", rt_pc, exp_pc[row]);
            check_equal("rfw_addr", rfw_addr, exp_reg[row]);
            check_equal("rfw_data", rfw_data, exp_val[row]);
            @(negedge clk); // step past this retire.
        end
        repeat (QUIET_CYCLES) begin
            check_equal("rfw_wen", rfw_wen, 32'd0);
            @(negedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/mips_pkg.sv
common/pipe_pkg.sv
design/fetch/fetch.sv
design/pipe_reg.sv
design/decode.sv
design/execute.sv
design/regfile.sv
design/datapath.sv
tb/datapath_props.sv
tb/datapath_tb.sv

// ==== Bender.yml ====
package:
  name: mips_datapath

sources:
  - include_dirs:
      - common
    files:
      - common/mips_pkg.sv
      - common/pipe_pkg.sv
      - design/fetch/fetch.sv
      - design/pipe_reg.sv
      - design/decode.sv
      - design/execute.sv
      - design/regfile.sv
      - design/datapath.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/datapath_props.sv
      - tb/datapath_tb.sv
